// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= frontend_tb
DUT_TOP    ?= frontend_top
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) \
		design/core_pkg.sv design/pipe_pkg.sv design/inst_memory.sv \
		design/fetch_stage.sv design/register_file.sv design/operand_bypass.sv \
		design/decode_stage.sv design/frontend_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/core_pkg.sv
package core_pkg;

    // Datapath and register file sizing
    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [XLEN-1:0] data_t;
    typedef logic [XLEN-1:0] inst_t;

    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

    // Instruction store
    localparam int IMEM_WORDS = 256;

    typedef logic [$clog2(IMEM_WORDS)-1:0] imem_idx_t;  // PC bits 9:2

    localparam inst_t NOP_INST = 32'h0000_0013;         // addi x0, x0, 0

    // Sequential fetch advances one word
    localparam int PC_STEP = 4;

    // Source register fields of an RV32 instruction
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;

    // Next PC source
    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,  // pc + 4
        PC_BRANCH = 2'd1,
        PC_JAL    = 2'd2,
        PC_JALR   = 2'd3
    } pc_sel_e;

endpackage

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 freeze,
    input  pipe_pkg::fetch_t     fetch,
    input  pipe_pkg::wb_write_t  wb,
    input  pipe_pkg::fwd_src_t   ex_fwd,
    input  pipe_pkg::fwd_src_t   mm_fwd,
    input  pipe_pkg::load_info_t load,
    input  pipe_pkg::src_use_t   src_use,
    output core_pkg::addr_t      id_pc,
    output core_pkg::inst_t      id_inst,
    output core_pkg::data_t      operand_a,
    output core_pkg::data_t      operand_b,
    output logic                 hazard
);

    import core_pkg::*;

    reg_idx_t rs1;
    reg_idx_t rs2;
    data_t    file_a;
    data_t    file_b;
    logic     rs1_conflict;
    logic     rs2_conflict;

    // IF/ID register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_pc   <= '0;
            id_inst <= NOP_INST;
        end else if (!freeze) begin
            id_pc   <= fetch.pc;
            id_inst <= fetch.inst;
        end
    end

    assign rs1 = id_inst[RS1_LSB +: $bits(reg_idx_t)];
    assign rs2 = id_inst[RS2_LSB +: $bits(reg_idx_t)];

    // Load result not ready until after memory
    assign rs1_conflict = src_use.has_rs1 && (rs1 == load.rd);
    assign rs2_conflict = src_use.has_rs2 && (rs2 == load.rd);
    assign hazard       = load.is_load && (rs1_conflict || rs2_conflict);

    register_file register_file_inst (
        .clk    (clk),
        .reset  (reset),
        .wb     (wb),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (file_a),
        .rdata2 (file_b)
    );

    operand_bypass bypass_a (
        .rs        (rs1),
        .file_data (file_a),
        .ex_fwd    (ex_fwd),
        .mm_fwd    (mm_fwd),
        .operand   (operand_a)
    );

    operand_bypass bypass_b (
        .rs        (rs2),
        .file_data (file_b),
        .ex_fwd    (ex_fwd),
        .mm_fwd    (mm_fwd),
        .operand   (operand_b)
    );

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                freeze,
    input  pipe_pkg::redirect_t redirect,
    input  logic                imem_we,
    input  core_pkg::inst_t     imem_wdata,
    output pipe_pkg::fetch_t    fetch
);

    import core_pkg::*;

    addr_t     pc;
    addr_t     pc4;
    addr_t     pc_next;
    imem_idx_t imem_index;
    inst_t     inst;

    assign pc4 = pc + addr_t'(PC_STEP);

    always_comb begin
        case (redirect.sel)
            PC_BRANCH: pc_next = redirect.branch_target;
            PC_JAL:    pc_next = redirect.jal_target;
            PC_JALR:   pc_next = redirect.jalr_target;
            default:   pc_next = pc4;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (!freeze) begin
            pc <= pc_next;
        end
    end

    // Word index drops the byte offset
    assign imem_index = pc[$clog2(PC_STEP) +: $bits(imem_idx_t)];

    inst_memory inst_memory_inst (
        .clk   (clk),
        .index (imem_index),
        .we    (imem_we),
        .wdata (imem_wdata),
        .rdata (inst)
    );

    assign fetch.pc   = pc;
    assign fetch.pc4  = pc4;
    assign fetch.inst = inst;

endmodule

// File: design/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  pipe_pkg::redirect_t  redirect,
    input  logic                 imem_we,
    input  core_pkg::inst_t      imem_wdata,
    input  pipe_pkg::wb_write_t  wb,
    input  pipe_pkg::fwd_src_t   ex_fwd,
    input  pipe_pkg::fwd_src_t   mm_fwd,
    input  pipe_pkg::load_info_t load,
    input  pipe_pkg::src_use_t   src_use,
    output core_pkg::addr_t      pc,
    output core_pkg::addr_t      pc4,
    output core_pkg::addr_t      id_pc,
    output core_pkg::inst_t      id_inst,
    output core_pkg::data_t      operand_a,
    output core_pkg::data_t      operand_b,
    output logic                 hazard
);

    import pipe_pkg::*;

    fetch_t fetch;
    logic   freeze;

    // Load-use hazard holds the PC too, nothing gets dropped
    assign freeze = stall || hazard;

    fetch_stage fetch_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .freeze     (freeze),
        .redirect   (redirect),
        .imem_we    (imem_we),
        .imem_wdata (imem_wdata),
        .fetch      (fetch)
    );

    decode_stage decode_stage_inst (
        .clk       (clk),
        .reset     (reset),
        .freeze    (freeze),
        .fetch     (fetch),
        .wb        (wb),
        .ex_fwd    (ex_fwd),
        .mm_fwd    (mm_fwd),
        .load      (load),
        .src_use   (src_use),
        .id_pc     (id_pc),
        .id_inst   (id_inst),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .hazard    (hazard)
    );

    assign pc  = fetch.pc;
    assign pc4 = fetch.pc4;

endmodule

// File: design/inst_memory.sv
`timescale 1ns/1ps

module inst_memory (
    input  logic                clk,
    input  core_pkg::imem_idx_t index,
    input  logic                we,
    input  core_pkg::inst_t     wdata,
    output core_pkg::inst_t     rdata
);

    import core_pkg::*;

    inst_t mem [0:IMEM_WORDS-1];

    // Power-up contents, reset leaves the program in place
    initial begin
        for (int i = 0; i < IMEM_WORDS; i++) begin
            mem[i] = NOP_INST;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index];  // Async read

endmodule

// File: design/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    input  core_pkg::reg_idx_t rs,
    input  core_pkg::data_t    file_data,
    input  pipe_pkg::fwd_src_t ex_fwd,
    input  pipe_pkg::fwd_src_t mm_fwd,
    output core_pkg::data_t    operand
);

    logic ex_hit;
    logic mm_hit;

    assign ex_hit = ex_fwd.wr_en && (ex_fwd.rd == rs) && (rs != '0);
    assign mm_hit = mm_fwd.wr_en && (mm_fwd.rd == rs) && (rs != '0);

    always_comb begin
        if (ex_hit) begin
            operand = ex_fwd.result;  // Youngest producer first
        end else if (mm_hit) begin
            operand = mm_fwd.is_load ? mm_fwd.mem_data : mm_fwd.result;
        end else begin
            operand = file_data;
        end
    end

endmodule

// File: design/pipe_pkg.sv
package pipe_pkg;

    import core_pkg::*;

    // Next PC request from later stages
    typedef struct packed {
        pc_sel_e sel;
        addr_t   branch_target;
        addr_t   jal_target;
        addr_t   jalr_target;
    } redirect_t;

    // Fetch to decode bundle
    typedef struct packed {
        addr_t pc;
        addr_t pc4;
        inst_t inst;
    } fetch_t;

    // Register file write port
    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        data_t    data;
    } wb_write_t;

    // One forwarding source, execute leaves the load fields at zero
    typedef struct packed {
        logic     wr_en;
        reg_idx_t rd;
        data_t    result;
        logic     is_load;
        data_t    mem_data;
    } fwd_src_t;

    // Instruction currently in execute
    typedef struct packed {
        logic     is_load;
        reg_idx_t rd;
    } load_info_t;

    // Which sources the decode instruction actually reads
    typedef struct packed {
        logic has_rs1;
        logic has_rs2;
    } src_use_t;

endpackage

// File: design/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                clk,
    input  logic                reset,
    input  pipe_pkg::wb_write_t wb,
    input  core_pkg::reg_idx_t  rs1,
    input  core_pkg::reg_idx_t  rs2,
    output core_pkg::data_t     rdata1,
    output core_pkg::data_t     rdata2
);

    import core_pkg::*;

    data_t regs [0:REG_COUNT-1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.rd != '0) begin  // x0 stays zero
            regs[wb.rd] <= wb.data;
        end
    end

    // No write-through, a same-cycle read sees the old value
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: src.f
design/core_pkg.sv
design/pipe_pkg.sv
design/inst_memory.sv
design/fetch_stage.sv
design/register_file.sv
design/operand_bypass.sv
design/decode_stage.sv
design/frontend_top.sv
test/frontend_props.sv
test/frontend_tb.sv

// File: test/frontend_input.txt
# st sel btgt jtgt rtgt we wdata | wb_en wb_rd wb_data | ex_wr ex_rd ex_res | mm_wr mm_rd mm_res mm_ld mm_mem | ld ld_rd has1 has2
# then expected: pc id_pc id_inst operand_a operand_b hazard (all hex)
0 0 0 0 0 1 002081b3 1 1 11 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00000013 0 0 0
0 0 0 0 0 1 404182b3 1 2 22 0 0 0 0 0 0 0 0 0 0 0 0 4 0 00000013 0 0 0
0 0 0 0 0 1 00100333 1 0 dead 0 0 0 0 0 0 0 0 0 0 0 0 8 4 00000013 0 0 0
0 1 0 44 48 1 002173b3 1 4 44 0 0 0 0 0 0 0 0 0 0 0 0 c 8 00000013 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 c 00000013 0 0 0
0 0 0 0 0 0 0 1 3 33 0 0 0 0 0 0 0 0 0 0 0 0 4 0 002081b3 11 22 0
0 0 0 0 0 0 0 1 4 45 0 0 0 0 0 0 0 0 0 0 0 0 8 4 404182b3 33 44 0
0 0 0 0 0 0 0 0 0 0 1 0 bad 0 0 0 0 0 0 0 0 0 c 8 00100333 0 11 0
1 0 0 0 0 0 0 0 0 0 1 2 e2 1 2 f2 0 0 0 0 0 0 10 c 002173b3 e2 e2 0
1 0 0 0 0 0 0 0 0 0 0 2 e2 1 2 f2 1 d2 0 0 0 0 10 c 002173b3 d2 d2 0
1 0 0 0 0 0 0 0 0 0 0 2 e2 0 2 f2 1 d2 0 0 0 0 10 c 002173b3 22 22 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 1 0 10 c 002173b3 22 22 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 0 1 10 c 002173b3 22 22 1
0 1 100 1f0 1f8 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 0 0 10 c 002173b3 22 22 0
0 2 2f0 200 2f8 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 100 10 00000013 0 0 0
0 3 300 400 c 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 200 100 00000013 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 c 200 00000013 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10 c 002173b3 22 22 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 14 10 00000013 0 0 0

// File: test/frontend_props.sv
`timescale 1ns/1ps

module frontend_props (
    input logic            clk,
    input logic            reset,
    input logic            freeze,
    input core_pkg::addr_t pc,
    input core_pkg::inst_t id_inst,
    input core_pkg::data_t operand_a,
    input logic            hazard
);

    import core_pkg::*;

    reg_idx_t rs1;

    assign rs1 = id_inst[RS1_LSB +: $bits(reg_idx_t)];

    // Freeze holds fetch and the IF/ID register
    assert property (@(posedge clk) disable iff (reset)
        freeze |=> (pc == $past(pc)) && (id_inst == $past(id_inst)))
        else $error("pc or id_inst moved during freeze");

    // x0 is never forwarded
    assert property (@(posedge clk) disable iff (reset)
        (rs1 == '0) |-> (operand_a == '0))
        else $error("operand_a nonzero with rs1 x0");

    assert property (@(posedge clk)
        $fell(reset) |-> !hazard)
        else $error("hazard high right after reset release");

endmodule

bind frontend_top frontend_props frontend_props_inst (
    .clk       (clk),
    .reset     (reset),
    .freeze    (freeze),
    .pc        (pc),
    .id_inst   (id_inst),
    .operand_a (operand_a),
    .hazard    (hazard)
);

// File: test/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;

    import core_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 10;
    localparam int MAX_CYCLES    = 200;  // Vector lines allowed before giving up
    localparam int RESET_TIMEOUT = 20;
    localparam int NUM_FIELDS    = 28;

    logic       clk;
    logic       reset;
    logic       stall;
    redirect_t  redirect;
    logic       imem_we;
    inst_t      imem_wdata;
    wb_write_t  wb;
    fwd_src_t   ex_fwd;
    fwd_src_t   mm_fwd;
    load_info_t load;
    src_use_t   src_use;
    addr_t      pc;
    addr_t      pc4;
    addr_t      id_pc;
    inst_t      id_inst;
    data_t      operand_a;
    data_t      operand_b;
    logic       hazard;

    logic [31:0] f [0:NUM_FIELDS-1];  // One parsed vector line
    int          fd;
    int          line_no;
    int          vectors_checked;
    int          wait_count;
    int          field_count;
    string       line;

    frontend_top frontend_top_inst (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .redirect   (redirect),
        .imem_we    (imem_we),
        .imem_wdata (imem_wdata),
        .wb         (wb),
        .ex_fwd     (ex_fwd),
        .mm_fwd     (mm_fwd),
        .load       (load),
        .src_use    (src_use),
        .pc         (pc),
        .pc4        (pc4),
        .id_pc      (id_pc),
        .id_inst    (id_inst),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .hazard     (hazard)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // Called on the rising edge, so the DUT sees the values from the next cycle
    task automatic apply_vector();
        stall      <= f[0][0];
        redirect   <= '{sel: pc_sel_e'(f[1][1:0]), branch_target: f[2],
                        jal_target: f[3], jalr_target: f[4]};
        imem_we    <= f[5][0];
        imem_wdata <= f[6];
        wb         <= '{en: f[7][0], rd: reg_idx_t'(f[8]), data: f[9]};
        ex_fwd     <= '{wr_en: f[10][0], rd: reg_idx_t'(f[11]), result: f[12],
                        is_load: 1'b0, mem_data: '0};
        mm_fwd     <= '{wr_en: f[13][0], rd: reg_idx_t'(f[14]), result: f[15],
                        is_load: f[16][0], mem_data: f[17]};
        load       <= '{is_load: f[18][0], rd: reg_idx_t'(f[19])};
        src_use    <= '{has_rs1: f[20][0], has_rs2: f[21][0]};
    endtask

    task automatic compare_outputs();
        check_addr("pc", pc, f[22]);
        check_addr("pc4", pc4, f[22] + 32'd4);
        check_addr("id_pc", id_pc, f[23]);
        check_inst("id_inst", id_inst, f[24]);
        check_data("operand_a", operand_a, f[25]);
        check_data("operand_b", operand_b, f[26]);
        check_bit("hazard", hazard, f[27][0]);
    endtask

    initial begin
        // Stall held through reset so the PC is still 0 on the first vector
        reset      = 1'b1;
        stall      = 1'b1;
        redirect   = '0;
        imem_we    = 1'b0;
        imem_wdata = '0;
        wb         = '0;
        ex_fwd     = '0;
        mm_fwd     = '0;
        load       = '0;
        src_use    = '0;
        line_no         = 0;
        vectors_checked = 0;

        fd = $fopen("test/frontend_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file test/frontend_input.txt");
            $display("Regression failed");
            $fatal(1);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        wait_count = 0;
        while (reset !== 1'b0) begin
            @(negedge clk);
            wait_count++;
            if (wait_count > RESET_TIMEOUT) begin
                $display("Reset was never released");
                $display("Regression failed");
                $fatal(1);
            end
        end

        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if (line.len() < 2 || line.getc(0) == 8'h23) begin  // Blank or # comment
                continue;
            end
            field_count = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                f[20], f[21], f[22], f[23], f[24], f[25], f[26], f[27]);
            if (field_count != NUM_FIELDS) begin
                $display("Vector line %0d has %0d fields instead of %0d",
                         line_no, field_count, NUM_FIELDS);
                $display("Regression failed");
                $fatal(1);
            end
            if (vectors_checked >= MAX_CYCLES) begin
                $display("Timeout after %0d vector cycles", MAX_CYCLES);
                $display("Regression failed");
                $fatal(1);
            end
            @(posedge clk);
            apply_vector();
            #(CLK_PERIOD - 1);
            compare_outputs();
            vectors_checked++;
        end
        $fclose(fd);

        if (vectors_checked > 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("No vectors were found in the vector file");
            $display("Regression failed");
            $fatal(1);
        end
    end

endmodule
